// ==== src/fb_geometry_pkg.sv ====
package fb_geometry_pkg;

    localparam int ADDR_WIDTH = 21;
    localparam int NUM_FRAMES = 3;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [1:0] buf_idx_t;

    // frames sit back to back, one burst of slack after each
    function automatic addr_t frame_base(
        buf_idx_t idx,
        int width,
        int height,
        int burst
    );
        int words;
        words = width * height + burst;
        return addr_t'(int'(idx) * words);
    endfunction

    // bursts per frame, last one may be partial
    function automatic int frame_bursts(
        int width,
        int height,
        int burst
    );
        return (width * height + burst - 1) / burst;
    endfunction

endpackage

// ==== src/fb_ctrl_pkg.sv ====
package fb_ctrl_pkg;

    typedef enum logic [2:0] {
        BUF_AVAILABLE  = 3'd0,
        BUF_WRITE_BUSY = 3'd1,
        BUF_READ_BUSY  = 3'd2,
        BUF_DISPLAYED  = 3'd3,
        BUF_UPDATED    = 3'd4
    } buf_state_e;

    typedef enum logic {
        ROLE_PRODUCER = 1'b0,
        ROLE_CONSUMER = 1'b1
    } role_e;

    typedef enum logic {
        EV_SELECT  = 1'b0,
        EV_RELEASE = 1'b1
    } ev_kind_e;

    // arbiter slots, lower index wins
    localparam int SLOT_PRODUCER = 0;
    localparam int SLOT_CONSUMER = 1;
    localparam int SLOT_WRITER   = 2;
    localparam int SLOT_READER   = 3;
    localparam int NUM_SLOTS     = 4;

    typedef struct packed {
        logic                      sel;
        logic                      rel;
        role_e                     role;
        fb_geometry_pkg::buf_idx_t idx;
    } table_op_t;

    typedef struct packed {
        logic                   en;
        logic                   wr;
        fb_geometry_pkg::addr_t addr;
    } mem_cmd_t;

    typedef struct packed {
        logic                      strobe;
        ev_kind_e                  kind;
        role_e                     role;
        fb_geometry_pkg::buf_idx_t idx;
    } frame_status_t;

endpackage

// ==== src/startup_delay_timer.sv ====
`timescale 1ns/1ps

module startup_delay_timer #(
    parameter int STARTUP_DELAY = 152
) (
    input  logic clk,
    input  logic rst_n,
    input  logic init_done_i,
    output logic delay_done_o
);

    localparam int CNT_W = $clog2(STARTUP_DELAY + 1);

    logic [CNT_W-1:0] count_q;

    // counts only while memory reports init, stops once done
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
            delay_done_o <= 1'b0;
        end else if (init_done_i && !delay_done_o) begin
            count_q <= count_q + 1'b1;
            // done rises together with the final count
            if (count_q == CNT_W'(STARTUP_DELAY - 1)) begin
                delay_done_o <= 1'b1;
            end
        end
    end

    a_done_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        delay_done_o |=> delay_done_o
    ) else $error("startup done level dropped");

endmodule

// ==== src/buffer_sequencer.sv ====
`timescale 1ns/1ps

module buffer_sequencer #(
    parameter fb_ctrl_pkg::role_e ROLE = fb_ctrl_pkg::ROLE_PRODUCER,
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int MEMORY_BURST = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      delay_done_i,
    input  logic                      grant_i,
    input  fb_geometry_pkg::buf_idx_t sel_idx_i,
    input  logic                      frame_done_i,
    output logic                      req_o,
    output fb_ctrl_pkg::table_op_t    table_op_o,
    output logic                      frame_start_o,
    output fb_geometry_pkg::addr_t    base_addr_o
);

    import fb_geometry_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WAIT_DELAY,
        S_LOCK,
        S_SELECT,
        S_START,
        S_TRANSFER,
        S_RELEASE_WAIT,
        S_RELEASE
    } state_e;

    state_e   state_q;
    state_e   state_d;
    buf_idx_t idx_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: state_d = S_WAIT_DELAY;
            S_WAIT_DELAY: begin
                if (delay_done_i) begin
                    state_d = S_LOCK;
                end
            end
            S_LOCK: begin
                if (grant_i) begin
                    state_d = S_SELECT;
                end
            end
            S_SELECT: state_d = S_START;
            S_START: state_d = S_TRANSFER;
            S_TRANSFER: begin
                if (frame_done_i) begin
                    state_d = S_RELEASE_WAIT;
                end
            end
            S_RELEASE_WAIT: begin
                if (grant_i) begin
                    state_d = S_RELEASE;
                end
            end
            S_RELEASE: state_d = S_LOCK;
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            frame_start_o <= 1'b0;
        end else begin
            state_q <= state_d;
            frame_start_o <= (state_q == S_START);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_SELECT) begin
            idx_q <= sel_idx_i;
        end
    end

    // req drops in the strobe cycle, grant still held there
    assign req_o = (state_q == S_LOCK) || (state_q == S_RELEASE_WAIT);

    always_comb begin
        table_op_o.sel = (state_q == S_SELECT);
        table_op_o.rel = (state_q == S_RELEASE);
        table_op_o.role = ROLE;
        table_op_o.idx = idx_q;
    end

    assign base_addr_o = frame_base(idx_q, FRAME_WIDTH, FRAME_HEIGHT, MEMORY_BURST);

    a_op_granted: assert property (
        @(posedge clk) disable iff (!rst_n)
        (table_op_o.sel || table_op_o.rel) |-> grant_i
    ) else $error("table strobe without grant");

endmodule

// ==== src/metadata_arbiter.sv ====
`timescale 1ns/1ps

module metadata_arbiter (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [fb_ctrl_pkg::NUM_SLOTS-1:0] req_i,
    output logic [fb_ctrl_pkg::NUM_SLOTS-1:0] grant_o
);

    import fb_ctrl_pkg::*;

    logic [NUM_SLOTS-1:0] winner;

    // lowest active slot
    always_comb begin
        winner = '0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                winner = '0;
                winner[i] = 1'b1;
            end
        end
    end

    // a held grant only clears, so a free cycle always follows it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_o <= '0;
        end else if (grant_o == '0) begin
            grant_o <= winner;
        end else if ((grant_o & req_i) == '0) begin
            grant_o <= '0;
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant_o)
    ) else $error("more than one grant active");

endmodule

// ==== src/buffer_table.sv ====
`timescale 1ns/1ps

module buffer_table (
    input  logic                       clk,
    input  logic                       rst_n,
    input  fb_ctrl_pkg::table_op_t     prod_op_i,
    input  fb_ctrl_pkg::table_op_t     cons_op_i,
    output fb_geometry_pkg::buf_idx_t  prod_sel_o,
    output fb_geometry_pkg::buf_idx_t  cons_sel_o,
    output fb_ctrl_pkg::frame_status_t frame_status_o
);

    import fb_geometry_pkg::*;
    import fb_ctrl_pkg::*;

    buf_state_e            state_q [NUM_FRAMES];
    logic [NUM_FRAMES-1:0] is_avail;
    logic [NUM_FRAMES-1:0] is_disp;
    logic [NUM_FRAMES-1:0] is_upd;
    table_op_t             op;
    logic                  op_strobe;
    buf_idx_t              op_idx;
    buf_state_e            op_state;

    // highest index of the first non-empty class
    function automatic buf_idx_t pick_highest(
        logic [NUM_FRAMES-1:0] first,
        logic [NUM_FRAMES-1:0] second,
        logic [NUM_FRAMES-1:0] third
    );
        logic [NUM_FRAMES-1:0] mask;
        buf_idx_t idx;
        if (first != '0) begin
            mask = first;
        end else if (second != '0) begin
            mask = second;
        end else begin
            mask = third;
        end
        idx = '0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            if (mask[i]) begin
                idx = buf_idx_t'(i);
            end
        end
        return idx;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_FRAMES; i++) begin
            is_avail[i] = (state_q[i] == BUF_AVAILABLE);
            is_disp[i] = (state_q[i] == BUF_DISPLAYED);
            is_upd[i] = (state_q[i] == BUF_UPDATED);
        end
    end

    // busy buffers fall in no class and are never picked
    assign prod_sel_o = pick_highest(is_disp, is_avail, is_upd);
    assign cons_sel_o = pick_highest(is_upd, is_avail, is_disp);

    // the arbiter lets only one side strobe at a time
    always_comb begin
        op = (prod_op_i.sel || prod_op_i.rel) ? prod_op_i : cons_op_i;
        op_strobe = op.sel || op.rel;
        if (op.sel) begin
            op_idx = (op.role == ROLE_PRODUCER) ? prod_sel_o : cons_sel_o;
            op_state = (op.role == ROLE_PRODUCER) ? BUF_WRITE_BUSY : BUF_READ_BUSY;
        end else begin
            op_idx = op.idx;
            op_state = (op.role == ROLE_PRODUCER) ? BUF_UPDATED : BUF_DISPLAYED;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_FRAMES; i++) begin
                state_q[i] <= BUF_AVAILABLE;
            end
            frame_status_o <= '0;
        end else begin
            if (op_strobe) begin
                state_q[op_idx] <= op_state;
            end
            frame_status_o.strobe <= op_strobe;
            frame_status_o.kind <= op.rel ? EV_RELEASE : EV_SELECT;
            frame_status_o.role <= op.role;
            frame_status_o.idx <= op_idx;
        end
    end

    a_single_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        !((prod_op_i.sel || prod_op_i.rel) && (cons_op_i.sel || cons_op_i.rel))
    ) else $error("producer and consumer table ops collide");

endmodule

// ==== src/burst_cmd_engine.sv ====
`timescale 1ns/1ps

module burst_cmd_engine #(
    parameter bit WRITE        = 1'b0,
    parameter int FRAME_WIDTH  = 640,
    parameter int FRAME_HEIGHT = 480,
    parameter int MEMORY_BURST = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   frame_start_i,
    input  fb_geometry_pkg::addr_t base_addr_i,
    input  logic                   grant_i,
    output logic                   req_o,
    output fb_ctrl_pkg::mem_cmd_t  cmd_o,
    output logic                   frame_done_o
);

    import fb_geometry_pkg::*;

    localparam int BURSTS = frame_bursts(FRAME_WIDTH, FRAME_HEIGHT, MEMORY_BURST);
    localparam int CNT_W  = $clog2(BURSTS + 1);

    logic             active_q;
    logic [CNT_W-1:0] burst_cnt_q;
    addr_t            addr_q;
    logic             fire;

    // first granted cycle of a burst
    assign fire = req_o && grant_i;

    always_comb begin
        cmd_o.en = fire;
        cmd_o.wr = fire && WRITE;
        cmd_o.addr = fire ? addr_q : '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            req_o <= 1'b0;
            burst_cnt_q <= '0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            if (frame_start_i) begin
                active_q <= 1'b1;
                req_o <= 1'b1;
                burst_cnt_q <= '0;
            end else if (active_q) begin
                if (fire) begin
                    req_o <= 1'b0;
                    burst_cnt_q <= burst_cnt_q + 1'b1;
                    if (burst_cnt_q == CNT_W'(BURSTS - 1)) begin
                        active_q <= 1'b0;
                        frame_done_o <= 1'b1;
                    end
                end else if (!req_o) begin
                    // port stays free for the cycle after each burst
                    req_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_start_i) begin
            addr_q <= base_addr_i;
        end else if (fire) begin
            addr_q <= addr_q + addr_t'(MEMORY_BURST);
        end
    end

    a_start_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_start_i |-> !active_q
    ) else $error("frame start while a frame is active");

endmodule

// ==== src/frame_buffer_ctrl.sv ====
`timescale 1ns/1ps

module frame_buffer_ctrl #(
    parameter int FRAME_WIDTH   = 640,
    parameter int FRAME_HEIGHT  = 480,
    parameter int MEMORY_BURST  = 32,
    parameter int STARTUP_DELAY = 152
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       init_done_i,
    output logic                       cmd_en_o,
    output logic                       cmd_o,
    output fb_geometry_pkg::addr_t     addr_o,
    output fb_ctrl_pkg::frame_status_t frame_status_o
);

    import fb_geometry_pkg::*;
    import fb_ctrl_pkg::*;

    logic                 delay_done;
    logic [NUM_SLOTS-1:0] arb_req;
    logic [NUM_SLOTS-1:0] arb_grant;
    logic                 prod_req;
    logic                 cons_req;
    logic                 wr_req;
    logic                 rd_req;
    table_op_t            prod_op;
    table_op_t            cons_op;
    buf_idx_t             prod_sel;
    buf_idx_t             cons_sel;
    logic                 prod_start;
    logic                 cons_start;
    addr_t                prod_base;
    addr_t                cons_base;
    logic                 wr_done;
    logic                 rd_done;
    mem_cmd_t             wr_cmd;
    mem_cmd_t             rd_cmd;
    mem_cmd_t             port_cmd;

    if (MEMORY_BURST != 16 && MEMORY_BURST != 32 &&
        MEMORY_BURST != 64 && MEMORY_BURST != 128) begin : g_bad_burst
        $error("unsupported MEMORY_BURST %0d", MEMORY_BURST);
    end

    startup_delay_timer #(
        .STARTUP_DELAY(STARTUP_DELAY)
    ) u_delay (
        .clk(clk),
        .rst_n(rst_n),
        .init_done_i(init_done_i),
        .delay_done_o(delay_done)
    );

    buffer_sequencer #(
        .ROLE(ROLE_PRODUCER),
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT),
        .MEMORY_BURST(MEMORY_BURST)
    ) u_prod_seq (
        .clk(clk),
        .rst_n(rst_n),
        .delay_done_i(delay_done),
        .grant_i(arb_grant[SLOT_PRODUCER]),
        .sel_idx_i(prod_sel),
        .frame_done_i(wr_done),
        .req_o(prod_req),
        .table_op_o(prod_op),
        .frame_start_o(prod_start),
        .base_addr_o(prod_base)
    );

    buffer_sequencer #(
        .ROLE(ROLE_CONSUMER),
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT),
        .MEMORY_BURST(MEMORY_BURST)
    ) u_cons_seq (
        .clk(clk),
        .rst_n(rst_n),
        .delay_done_i(delay_done),
        .grant_i(arb_grant[SLOT_CONSUMER]),
        .sel_idx_i(cons_sel),
        .frame_done_i(rd_done),
        .req_o(cons_req),
        .table_op_o(cons_op),
        .frame_start_o(cons_start),
        .base_addr_o(cons_base)
    );

    always_comb begin
        arb_req = '0;
        arb_req[SLOT_PRODUCER] = prod_req;
        arb_req[SLOT_CONSUMER] = cons_req;
        arb_req[SLOT_WRITER] = wr_req;
        arb_req[SLOT_READER] = rd_req;
    end

    metadata_arbiter u_arb (
        .clk(clk),
        .rst_n(rst_n),
        .req_i(arb_req),
        .grant_o(arb_grant)
    );

    buffer_table u_table (
        .clk(clk),
        .rst_n(rst_n),
        .prod_op_i(prod_op),
        .cons_op_i(cons_op),
        .prod_sel_o(prod_sel),
        .cons_sel_o(cons_sel),
        .frame_status_o(frame_status_o)
    );

    burst_cmd_engine #(
        .WRITE(1'b1),
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT),
        .MEMORY_BURST(MEMORY_BURST)
    ) u_writer (
        .clk(clk),
        .rst_n(rst_n),
        .frame_start_i(prod_start),
        .base_addr_i(prod_base),
        .grant_i(arb_grant[SLOT_WRITER]),
        .req_o(wr_req),
        .cmd_o(wr_cmd),
        .frame_done_o(wr_done)
    );

    burst_cmd_engine #(
        .WRITE(1'b0),
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT),
        .MEMORY_BURST(MEMORY_BURST)
    ) u_reader (
        .clk(clk),
        .rst_n(rst_n),
        .frame_start_i(cons_start),
        .base_addr_i(cons_base),
        .grant_i(arb_grant[SLOT_READER]),
        .req_o(rd_req),
        .cmd_o(rd_cmd),
        .frame_done_o(rd_done)
    );

    // idle engines drive all zeros, so a plain OR merges them
    assign port_cmd = wr_cmd | rd_cmd;
    assign cmd_en_o = port_cmd.en;
    assign cmd_o = port_cmd.wr;
    assign addr_o = port_cmd.addr;

    a_port_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr_cmd.en && rd_cmd.en)
    ) else $error("writer and reader commands collide");

endmodule

// ==== testbench/tb_frame_buffer_ctrl.sv ====
`timescale 1ns/1ps

module tb_frame_buffer_ctrl;

    import fb_geometry_pkg::*;
    import fb_ctrl_pkg::*;

    localparam int FRAME_WIDTH = 8;
    localparam int FRAME_HEIGHT = 4;
    localparam int MEMORY_BURST = 16;
    localparam int STARTUP_DELAY = 10;
    localparam int RESET_CYCLES = 8;
    localparam int FRAMES_PER_ROLE = 4;
    localparam int NUM_BUF = 3;
    localparam int INIT_WAIT_MAX = 4 + 31;
    localparam int BURSTS_PER_FRAME = (FRAME_WIDTH * FRAME_HEIGHT + MEMORY_BURST - 1) / MEMORY_BURST;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + INIT_WAIT_MAX
        + FRAMES_PER_ROLE * (BURSTS_PER_FRAME * 8 + STARTUP_DELAY + 64);

    // model buffer states
    localparam int ST_AVAIL = 0;
    localparam int ST_WRITE_BUSY = 1;
    localparam int ST_READ_BUSY = 2;
    localparam int ST_DISPLAYED = 3;
    localparam int ST_UPDATED = 4;

    logic          clk;
    logic          rst_n;
    logic          init_done_i;
    logic          cmd_en_o;
    logic          cmd_o;
    addr_t         addr_o;
    frame_status_t frame_status_o;

    logic [31:0] lfsr_state;
    int          model [NUM_BUF];
    int          held_idx [2];
    bit          frame_open [2];
    int          burst_seen [2];
    int          err_at_sel [2];
    int          frames_done [2];
    int          error_count;
    int          tests_run;
    int          tests_failed;
    int          since_init;
    bit          activity_seen;
    int          init_wait;

    frame_buffer_ctrl #(
        .FRAME_WIDTH(FRAME_WIDTH),
        .FRAME_HEIGHT(FRAME_HEIGHT),
        .MEMORY_BURST(MEMORY_BURST),
        .STARTUP_DELAY(STARTUP_DELAY)
    ) DUT (
        .clk(clk),
        .rst_n(rst_n),
        .init_done_i(init_done_i),
        .cmd_en_o(cmd_en_o),
        .cmd_o(cmd_o),
        .addr_o(addr_o),
        .frame_status_o(frame_status_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb) begin
            s = s ^ 32'h80200003;
        end
        return s;
    endfunction

    // one step per bit taken
    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    function automatic int expected_base(input int idx);
        return idx * (FRAME_WIDTH * FRAME_HEIGHT + MEMORY_BURST);
    endfunction

    // highest index of the first class that holds a buffer
    function automatic int expected_select(input int role);
        int order [3];
        int pick;
        if (role == 0) begin
            order = '{ST_DISPLAYED, ST_AVAIL, ST_UPDATED};
        end else begin
            order = '{ST_UPDATED, ST_AVAIL, ST_DISPLAYED};
        end
        pick = -1;
        for (int c = 0; c < 3; c++) begin
            if (pick < 0) begin
                for (int i = 0; i < NUM_BUF; i++) begin
                    if (model[i] == order[c]) begin
                        pick = i;
                    end
                end
            end
        end
        return pick;
    endfunction

    task automatic report_mismatch(input string name, input int exp, input int got);
        $display("ERROR %0t: %s expected %0d got %0d", $time, name, exp, got);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("%0t: %s", $time, msg);
        error_count++;
    endtask

    task automatic handle_status();
        int r;
        int idx;
        int exp_idx;
        string who;
        r = (frame_status_o.role == ROLE_CONSUMER) ? 1 : 0;
        idx = int'(frame_status_o.idx);
        who = (r == 0) ? "producer" : "consumer";
        if (frame_status_o.kind == EV_SELECT) begin
            exp_idx = expected_select(r);
            assert (idx == exp_idx) else report_mismatch("frame_status_o.idx", exp_idx, idx);
            assert (!frame_open[r]) else report_problem({who, " selected again before release"});
            assert (!(frame_open[1-r] && held_idx[1-r] == idx))
                else report_problem("both roles hold the same buffer");
            if (idx < NUM_BUF) begin
                model[idx] = (r == 0) ? ST_WRITE_BUSY : ST_READ_BUSY;
            end
            held_idx[r] = idx;
            frame_open[r] = 1'b1;
            burst_seen[r] = 0;
            err_at_sel[r] = error_count;
        end else begin
            assert (frame_open[r]) else report_problem({who, " released without a select"});
            assert (idx == held_idx[r]) else report_mismatch("frame_status_o.idx", held_idx[r], idx);
            assert (burst_seen[r] == BURSTS_PER_FRAME)
                else report_mismatch("command count", BURSTS_PER_FRAME, burst_seen[r]);
            if (idx < NUM_BUF) begin
                model[idx] = (r == 0) ? ST_UPDATED : ST_DISPLAYED;
            end
            frame_open[r] = 1'b0;
            frames_done[r]++;
            tests_run++;
            if (error_count == err_at_sel[r]) begin
                $display("frame %0d %s buffer %0d: pass", frames_done[r], who, idx);
            end else begin
                tests_failed++;
                $display("frame %0d %s buffer %0d: fail", frames_done[r], who, idx);
            end
        end
    endtask

    task automatic check_command();
        int r;
        int exp_addr;
        if (!cmd_en_o) begin
            assert (addr_o == '0) else report_mismatch("addr_o", 0, int'(addr_o));
        end else begin
            // write commands belong to the producer frame
            r = cmd_o ? 0 : 1;
            assert (frame_open[r]) else report_problem("memory command outside any frame");
            if (frame_open[r]) begin
                assert (burst_seen[r] < BURSTS_PER_FRAME)
                    else report_problem("more commands than bursts in a frame");
                exp_addr = expected_base(held_idx[r]) + burst_seen[r] * MEMORY_BURST;
                assert (int'(addr_o) == exp_addr)
                    else report_mismatch("addr_o", exp_addr, int'(addr_o));
                burst_seen[r]++;
            end
        end
    endtask

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        int errs_before;
        if (rst_n) begin
            if (init_done_i) begin
                since_init++;
            end
            if ((cmd_en_o || frame_status_o.strobe) && !activity_seen) begin
                activity_seen = 1'b1;
                errs_before = error_count;
                assert (since_init >= STARTUP_DELAY)
                    else report_problem("port activity before the startup delay ran out");
                tests_run++;
                if (error_count == errs_before) begin
                    $display("startup delay: pass after %0d cycles", since_init);
                end else begin
                    tests_failed++;
                    $display("startup delay: fail after %0d cycles", since_init);
                end
            end
            if (frame_status_o.strobe) begin
                handle_status();
            end
            check_command();
        end
    end

    initial begin
        rst_n = 1'b0;
        init_done_i = 1'b0;
        lfsr_state = 32'd91811;
        for (int i = 0; i < NUM_BUF; i++) begin
            model[i] = ST_AVAIL;
        end
        for (int r = 0; r < 2; r++) begin
            held_idx[r] = 0;
            frame_open[r] = 1'b0;
            burst_seen[r] = 0;
            err_at_sel[r] = 0;
            frames_done[r] = 0;
        end
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        since_init = 0;
        activity_seen = 1'b0;
        init_wait = 4 + random_bits(5);
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        repeat (init_wait) @(posedge clk);
        init_done_i <= 1'b1;
        wait (frames_done[0] >= FRAMES_PER_ROLE && frames_done[1] >= FRAMES_PER_ROLE);
        repeat (4) @(posedge clk);
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog ran out before every role finished its frames");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== frame_buffer_ctrl.f ====
src/fb_geometry_pkg.sv
src/fb_ctrl_pkg.sv
src/startup_delay_timer.sv
src/buffer_sequencer.sv
src/metadata_arbiter.sv
src/buffer_table.sv
src/burst_cmd_engine.sv
src/frame_buffer_ctrl.sv
testbench/tb_frame_buffer_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary -j 0 --assert --timing -Wno-fatal
TOP       = tb_frame_buffer_ctrl
FILELIST  = frame_buffer_ctrl.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)
